/* verilog.f */
design/ic_pkg.sv
design/cmd_fifo.sv
design/cmd_router.sv
design/resp_router.sv
design/cfg_regs.sv
design/loopback_slave.sv
design/mem_ic_top.sv
dv/mem_ic_chk.sv
dv/mem_ic_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mem_ic_tb
FILELIST  ?= verilog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/mem_ic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ic_tb
  import ic_pkg::*;
  ();

  localparam int CFG_REGS = 8;
  localparam int CMDS_PER_REQ = 150;
  localparam int TIMEOUT = 40 * (NUM_REQ * CMDS_PER_REQ) + 500;

  logic                   clk_i;
  logic                   arst_n_i;
  mem_msg_t [NUM_REQ-1:0] req_cmd_i;
  logic [NUM_REQ-1:0]     req_cmd_v_i;
  logic [NUM_REQ-1:0]     req_cmd_ready_o;
  mem_msg_t [NUM_REQ-1:0] req_resp_o;
  logic [NUM_REQ-1:0]     req_resp_v_o;
  logic [NUM_REQ-1:0]     req_resp_ready_i;
  mem_msg_t               dram_cmd_o;
  logic                   dram_cmd_v_o;
  logic                   dram_cmd_ready_i;
  mem_msg_t               dram_resp_i;
  logic                   dram_resp_v_i;
  logic                   dram_resp_yumi_o;
  mem_msg_t               io_cmd_o;
  logic                   io_cmd_v_o;
  logic                   io_cmd_ready_i;
  mem_msg_t               io_resp_i;
  logic                   io_resp_v_i;
  logic                   io_resp_yumi_o;

  // Queues indexed by requester * 4 + destination
  mem_msg_t exp_resp_q [NUM_REQ*4][$];
  mem_msg_t exp_cmd_q [NUM_REQ*4][$];
  // External models, 0 is io and 1 is dram
  mem_msg_t ext_q [2][$];
  int       ext_due [2][$];
  data_t    cfg_model [CFG_REGS];
  int       sent [NUM_REQ];
  logic [31:0] rng;
  int       cycles;
  int       checks;
  int       errors;
  logic     run;
  logic     done;

  mem_ic_top #(.CFG_REGS(CFG_REGS)) dut_i (.*);

  always #20 clk_i = ~clk_i;

  function logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic dest_e decode(input addr_t a);
    if (a < 40'h00_8000_0000)
    begin
      if (a[23:20] == 4'd2)
        return DEST_CFG;
      if (a[23:20] < 4'd2)
        return DEST_IO;
      return DEST_LOOPBACK;
    end
    return (a[39:37] != 3'd0) ? DEST_IO : DEST_DRAM;
  endfunction

  // Read-only backing store seen by both external ports
  function automatic data_t fill_data(input addr_t a);
    return {a[23:0], a} ^ 64'h9e37_79b9_7f4a_7c15;
  endfunction

  // Each requester owns cfg indices r and r+3, so its own order decides the data
  function mem_msg_t make_cmd(input int r);
    mem_msg_t    m;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [2:0]  dom;
    r1 = next_rand();
    r2 = next_rand();
    m.addr = {9'b0, r2[30:0]};
    case (r1 % 5)
      0:
      begin
        m.addr[23:20] = 4'd2;
        m.addr[5:3] = r1[3] ? 3'(r + 3) : 3'(r);
      end
      1: m.addr[23:20] = 4'd3 + 4'(r1[7:4] % 13);
      2: m.addr[23:20] = {3'b0, r1[8]};
      3:
      begin
        dom = r1[12:10];
        if (dom == 3'd0)
          dom = 3'd1;
        m.addr = {dom, r1[17:13], r2};
      end
      default: m.addr = {3'b000, r1[17:13], 1'b1, r2[30:0]};
    endcase
    m.op = r1[20];
    m.data = {next_rand(), next_rand()};
    m.src_id = src_id_t'(r);
    return m;
  endfunction

  task automatic record_cmd(input mem_msg_t m);
    dest_e    d;
    mem_msg_t exp;
    int       k;
    int       idx;
    d = decode(m.addr);
    k = int'(m.src_id) * 4 + int'(d);
    idx = int'(m.addr[5:3]) % CFG_REGS;
    exp = m;
    exp.data = '0;
    if (m.op == OP_READ && d == DEST_CFG)
      exp.data = cfg_model[idx];
    else if (m.op == OP_READ && (d == DEST_IO || d == DEST_DRAM))
      exp.data = fill_data(m.addr);
    if (m.op == OP_WRITE && d == DEST_CFG)
      cfg_model[idx] = m.data;
    if (d == DEST_IO || d == DEST_DRAM)
      exp_cmd_q[k].push_back(m);
    exp_resp_q[k].push_back(exp);
  endtask

  task automatic compare_msg(input string name, input mem_msg_t exp, input mem_msg_t got);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, got);
    end
  endtask

  task automatic check_resp(input int r);
    mem_msg_t m;
    int       k;
    m = req_resp_o[r];
    checks++;
    assert (m.src_id == src_id_t'(r))
    else
    begin
      errors++;
      $display("mismatch resp_lane%0d: expected %h, actual %h", r, r, m.src_id);
    end
    k = r * 4 + int'(decode(m.addr));
    assert (exp_resp_q[k].size() > 0)
    else
    begin
      errors++;
      $display("requester %0d got a response it never asked for", r);
    end
    if (exp_resp_q[k].size() > 0)
      compare_msg($sformatf("resp_req%0d", r), exp_resp_q[k].pop_front(), m);
  endtask

  task automatic ext_port(input int p);
    mem_msg_t m;
    logic     v;
    logic     rdy;
    logic     taken;
    int       k;
    m = p ? dram_cmd_o : io_cmd_o;
    v = p ? dram_cmd_v_o : io_cmd_v_o;
    rdy = p ? dram_cmd_ready_i : io_cmd_ready_i;
    taken = p ? (dram_resp_v_i & dram_resp_yumi_o) : (io_resp_v_i & io_resp_yumi_o);
    if (v && rdy)
    begin
      k = int'(m.src_id) * 4 + (p ? int'(DEST_DRAM) : int'(DEST_IO));
      assert (exp_cmd_q[k].size() > 0)
      else
      begin
        errors++;
        $display("command appeared on the %s port that was not routed there",
                 p ? "dram" : "io");
      end
      if (exp_cmd_q[k].size() > 0)
        compare_msg(p ? "dram_cmd" : "io_cmd", exp_cmd_q[k].pop_front(), m);
      if (m.op == OP_READ)
        m.data = fill_data(m.addr);
      else
        m.data = '0;
      ext_q[p].push_back(m);
      ext_due[p].push_back(cycles + int'(next_rand() % 8));
    end
    if (taken)
    begin
      void'(ext_q[p].pop_front());
      void'(ext_due[p].pop_front());
    end
    v = (ext_q[p].size() > 0) && (ext_due[p][0] <= cycles);
    m = (ext_q[p].size() > 0) ? ext_q[p][0] : '0;
    rdy = (next_rand() % 4) != 0;
    if (p == 1)
    begin
      dram_resp_v_i <= v;
      dram_resp_i <= m;
      dram_cmd_ready_i <= rdy;
    end
    else
    begin
      io_resp_v_i <= v;
      io_resp_i <= m;
      io_cmd_ready_i <= rdy;
    end
  endtask

  task automatic step_models();
    logic drained;
    drained = 1'b1;
    for (int r = 0; r < NUM_REQ; r++)
    begin
      if (req_resp_v_o[r] && req_resp_ready_i[r])
        check_resp(r);
      if (req_cmd_v_i[r] && req_cmd_ready_o[r])
        record_cmd(req_cmd_i[r]);
      // Count before a new command goes out
      if (sent[r] < CMDS_PER_REQ || req_cmd_v_i[r])
        drained = 1'b0;
      if (!req_cmd_v_i[r] || req_cmd_ready_o[r])
      begin
        if (sent[r] < CMDS_PER_REQ && (next_rand() % 4) != 0)
        begin
          req_cmd_i[r] <= make_cmd(r);
          req_cmd_v_i[r] <= 1'b1;
          sent[r]++;
        end
        else
          req_cmd_v_i[r] <= 1'b0;
      end
      req_resp_ready_i[r] <= (next_rand() % 4) != 0;
      for (int d = 0; d < 4; d++)
      begin
        if (exp_resp_q[r*4+d].size() > 0 || exp_cmd_q[r*4+d].size() > 0)
          drained = 1'b0;
      end
    end
    for (int p = 0; p < 2; p++)
      ext_port(p);
    done = drained;
  endtask

  always @(posedge clk_i)
  begin
    if (run)
    begin
      cycles++;
      if (cycles > TIMEOUT)
      begin
        $display("SOME TESTS FAILED");
        $display("timeout after %0d cycles with traffic still outstanding", cycles);
        $finish;
      end
      else
        step_models();
    end
  end

  initial
  begin
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    req_cmd_i = '0;
    req_cmd_v_i = '0;
    req_resp_ready_i = '0;
    dram_cmd_ready_i = 1'b0;
    dram_resp_i = '0;
    dram_resp_v_i = 1'b0;
    io_cmd_ready_i = 1'b0;
    io_resp_i = '0;
    io_resp_v_i = 1'b0;
    rng = 32'h8e978781;
    cycles = 0;
    checks = 0;
    errors = 0;
    run = 1'b0;
    done = 1'b0;
    for (int i = 0; i < CFG_REGS; i++)
      cfg_model[i] = '0;
    for (int r = 0; r < NUM_REQ; r++)
      sent[r] = 0;
    repeat (10) @(posedge clk_i);
    checks++;
    assert (req_resp_v_o == '0 && !dram_cmd_v_o && !io_cmd_v_o)
    else
    begin
      errors++;
      $display("a valid output was high during reset");
    end
    arst_n_i <= 1'b1;
    run <= 1'b1;
    @(posedge clk_i);
    while (!done)
      @(posedge clk_i);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/mem_ic_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ic_chk
  import ic_pkg::*;
  (  input  logic                   clk_i
   , input  logic                   arst_n_i
   , input  logic [NUM_REQ-1:0]     req_resp_v_i
   , input  logic                   dram_cmd_v_i
   , input  logic                   dram_cmd_ready_i
   , input  logic                   io_cmd_v_i
   , input  logic                   io_cmd_ready_i
   , input  mem_msg_t [NUM_REQ-1:0] head_i
   , input  logic [NUM_REQ-1:0]     head_v_i
   , input  logic [NUM_REQ-1:0]     head_yumi_i
   , input  logic                   cfg_cmd_v_i
   , input  logic                   loopback_cmd_v_i
   , input  mem_msg_t               cfg_resp_i
   , input  logic                   cfg_resp_v_i
   , input  logic                   cfg_resp_yumi_i
   , input  mem_msg_t               loopback_resp_i
   , input  logic                   loopback_resp_v_i
   , input  logic                   loopback_resp_yumi_i
  );

  a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |->
      (req_resp_v_i == '0) && !dram_cmd_v_i && !io_cmd_v_i && !cfg_resp_v_i
      && !loopback_resp_v_i)
    else $error("valid output high during reset");

  // Commands leave only in a cycle the port accepts them
  a_ext_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (!dram_cmd_v_i || dram_cmd_ready_i) && (!io_cmd_v_i || io_cmd_ready_i))
    else $error("external command valid without ready");

  a_one_dest: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0({dram_cmd_v_i, io_cmd_v_i, cfg_cmd_v_i, loopback_cmd_v_i}))
    else $error("command sent to more than one destination");

  a_one_lane: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(req_resp_v_i))
    else $error("response valid on more than one requester lane");

  // A waiting FIFO head keeps its command until it is dispatched
  for (genvar i = 0; i < NUM_REQ; i++)
  begin : lane
    a_head_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        head_v_i[i] && !head_yumi_i[i] |=> head_v_i[i] && $stable(head_i[i]))
      else $error("command at a FIFO head changed before it was dispatched");
  end

  a_cfg_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cfg_resp_v_i && !cfg_resp_yumi_i |=> cfg_resp_v_i && $stable(cfg_resp_i))
    else $error("cfg response changed before it was taken");

  a_loopback_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      loopback_resp_v_i && !loopback_resp_yumi_i |=>
      loopback_resp_v_i && $stable(loopback_resp_i))
    else $error("loopback response changed before it was taken");

endmodule

bind mem_ic_top mem_ic_chk chk_i
  (  .clk_i                (clk_i)
   , .arst_n_i             (arst_n_i)
   , .req_resp_v_i         (req_resp_v_o)
   , .dram_cmd_v_i         (dram_cmd_v_o)
   , .dram_cmd_ready_i     (dram_cmd_ready_i)
   , .io_cmd_v_i           (io_cmd_v_o)
   , .io_cmd_ready_i       (io_cmd_ready_i)
   , .head_i               (cmd_fifo_lo)
   , .head_v_i             (cmd_fifo_v_lo)
   , .head_yumi_i          (cmd_fifo_yumi_li)
   , .cfg_cmd_v_i          (cfg_cmd_v_li)
   , .loopback_cmd_v_i     (loopback_cmd_v_li)
   , .cfg_resp_i           (cfg_resp_lo)
   , .cfg_resp_v_i         (cfg_resp_v_lo)
   , .cfg_resp_yumi_i      (cfg_resp_yumi_li)
   , .loopback_resp_i      (loopback_resp_lo)
   , .loopback_resp_v_i    (loopback_resp_v_lo)
   , .loopback_resp_yumi_i (loopback_resp_yumi_li)
  );

`default_nettype wire

/* design/mem_ic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ic_top
  import ic_pkg::*;
  #(parameter int CFG_REGS = 8)
  (  input  logic                   clk_i
   , input  logic                   arst_n_i

   // Requesters
   , input  mem_msg_t [NUM_REQ-1:0] req_cmd_i
   , input  logic [NUM_REQ-1:0]     req_cmd_v_i
   , output logic [NUM_REQ-1:0]     req_cmd_ready_o

   , output mem_msg_t [NUM_REQ-1:0] req_resp_o
   , output logic [NUM_REQ-1:0]     req_resp_v_o
   , input  logic [NUM_REQ-1:0]     req_resp_ready_i

   // External DRAM
   , output mem_msg_t               dram_cmd_o
   , output logic                   dram_cmd_v_o
   , input  logic                   dram_cmd_ready_i

   , input  mem_msg_t               dram_resp_i
   , input  logic                   dram_resp_v_i
   , output logic                   dram_resp_yumi_o

   // External I/O
   , output mem_msg_t               io_cmd_o
   , output logic                   io_cmd_v_o
   , input  logic                   io_cmd_ready_i

   , input  mem_msg_t               io_resp_i
   , input  logic                   io_resp_v_i
   , output logic                   io_resp_yumi_o
  );

  mem_msg_t [NUM_REQ-1:0] cmd_fifo_lo;
  logic [NUM_REQ-1:0]     cmd_fifo_v_lo;
  logic [NUM_REQ-1:0]     cmd_fifo_yumi_li;

  mem_msg_t routed_cmd_lo;
  logic     cfg_cmd_v_li;
  logic     cfg_cmd_ready_lo;
  logic     loopback_cmd_v_li;
  logic     loopback_cmd_ready_lo;

  mem_msg_t cfg_resp_lo;
  logic     cfg_resp_v_lo;
  logic     cfg_resp_yumi_li;
  mem_msg_t loopback_resp_lo;
  logic     loopback_resp_v_lo;
  logic     loopback_resp_yumi_li;

  for (genvar i = 0; i < NUM_REQ; i++)
  begin : req_fifo
    cmd_fifo fifo
      (  .clk_i    (clk_i)
       , .arst_n_i (arst_n_i)
       , .data_i   (req_cmd_i[i])
       , .v_i      (req_cmd_v_i[i])
       , .ready_o  (req_cmd_ready_o[i])
       , .data_o   (cmd_fifo_lo[i])
       , .v_o      (cmd_fifo_v_lo[i])
       , .yumi_i   (cmd_fifo_yumi_li[i])
      );
  end

  cmd_router cmd_arb
    (  .fifo_data_i      (cmd_fifo_lo)
     , .fifo_v_i         (cmd_fifo_v_lo)
     , .fifo_yumi_o      (cmd_fifo_yumi_li)
     , .cmd_o            (routed_cmd_lo)
     , .cfg_v_o          (cfg_cmd_v_li)
     , .loopback_v_o     (loopback_cmd_v_li)
     , .io_v_o           (io_cmd_v_o)
     , .dram_v_o         (dram_cmd_v_o)
     , .cfg_ready_i      (cfg_cmd_ready_lo)
     , .loopback_ready_i (loopback_cmd_ready_lo)
     , .io_ready_i       (io_cmd_ready_i)
     , .dram_ready_i     (dram_cmd_ready_i)
    );

  // The selected head fans out to every destination
  assign dram_cmd_o = routed_cmd_lo;
  assign io_cmd_o   = routed_cmd_lo;

  cfg_regs #(.CFG_REGS(CFG_REGS)) cfg
    (  .clk_i       (clk_i)
     , .arst_n_i    (arst_n_i)
     , .cmd_i       (routed_cmd_lo)
     , .cmd_v_i     (cfg_cmd_v_li)
     , .cmd_ready_o (cfg_cmd_ready_lo)
     , .resp_o      (cfg_resp_lo)
     , .resp_v_o    (cfg_resp_v_lo)
     , .resp_yumi_i (cfg_resp_yumi_li)
    );

  loopback_slave loopback
    (  .clk_i       (clk_i)
     , .arst_n_i    (arst_n_i)
     , .cmd_i       (routed_cmd_lo)
     , .cmd_v_i     (loopback_cmd_v_li)
     , .cmd_ready_o (loopback_cmd_ready_lo)
     , .resp_o      (loopback_resp_lo)
     , .resp_v_o    (loopback_resp_v_lo)
     , .resp_yumi_i (loopback_resp_yumi_li)
    );

  resp_router resp_arb
    (  .cfg_resp_i           (cfg_resp_lo)
     , .cfg_resp_v_i         (cfg_resp_v_lo)
     , .cfg_resp_yumi_o      (cfg_resp_yumi_li)
     , .loopback_resp_i      (loopback_resp_lo)
     , .loopback_resp_v_i    (loopback_resp_v_lo)
     , .loopback_resp_yumi_o (loopback_resp_yumi_li)
     , .io_resp_i            (io_resp_i)
     , .io_resp_v_i          (io_resp_v_i)
     , .io_resp_yumi_o       (io_resp_yumi_o)
     , .dram_resp_i          (dram_resp_i)
     , .dram_resp_v_i        (dram_resp_v_i)
     , .dram_resp_yumi_o     (dram_resp_yumi_o)
     , .req_resp_o           (req_resp_o)
     , .req_resp_v_o         (req_resp_v_o)
     , .req_resp_ready_i     (req_resp_ready_i)
    );

endmodule

`default_nettype wire

/* design/loopback_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module loopback_slave
  import ic_pkg::*;
  (  input  logic     clk_i
   , input  logic     arst_n_i

   , input  mem_msg_t cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_t resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i
  );

  mem_msg_t resp_q;
  logic     resp_v_q;
  logic     accept;

  assign cmd_ready_o = ~resp_v_q;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  // Echo the header and answer with zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_q <= '{op: cmd_i.op, addr: cmd_i.addr, data: '0, src_id: cmd_i.src_id};
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

`default_nettype wire

/* design/cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  import ic_pkg::*;
  #(parameter int CFG_REGS = 8)
  (  input  logic     clk_i
   , input  logic     arst_n_i

   , input  mem_msg_t cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output mem_msg_t resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i
  );

  localparam int IDX_W = (CFG_REGS > 1) ? $clog2(CFG_REGS) : 1;

  data_t            regs_q [CFG_REGS];
  mem_msg_t         resp_q;
  logic             resp_v_q;
  cfg_idx_t         raw_idx;
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             is_write;

  // One outstanding response at a time
  assign cmd_ready_o = ~resp_v_q;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_i.op == OP_WRITE);

  // Index sits above the doubleword offset
  assign raw_idx = cmd_i.addr[3+:CFG_IDX_WIDTH];
  assign idx     = IDX_W'(raw_idx % CFG_REGS);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < CFG_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (accept && is_write)
      regs_q[idx] <= cmd_i.data;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (accept)
      resp_v_q <= 1'b1;
    else if (resp_yumi_i)
      resp_v_q <= 1'b0;
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.op     <= cmd_i.op;
      resp_q.addr   <= cmd_i.addr;
      resp_q.data   <= is_write ? '0 : regs_q[idx];
      resp_q.src_id <= cmd_i.src_id;
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

`default_nettype wire

/* design/resp_router.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_router
  import ic_pkg::*;
  (  input  mem_msg_t               cfg_resp_i
   , input  logic                   cfg_resp_v_i
   , output logic                   cfg_resp_yumi_o

   , input  mem_msg_t               loopback_resp_i
   , input  logic                   loopback_resp_v_i
   , output logic                   loopback_resp_yumi_o

   , input  mem_msg_t               io_resp_i
   , input  logic                   io_resp_v_i
   , output logic                   io_resp_yumi_o

   , input  mem_msg_t               dram_resp_i
   , input  logic                   dram_resp_v_i
   , output logic                   dram_resp_yumi_o

   , output mem_msg_t [NUM_REQ-1:0] req_resp_o
   , output logic [NUM_REQ-1:0]     req_resp_v_o
   , input  logic [NUM_REQ-1:0]     req_resp_ready_i
  );

  dest_e    grant_src;
  mem_msg_t resp_sel;
  logic     any_v;
  logic     take;

  assign any_v = loopback_resp_v_i | dram_resp_v_i | io_resp_v_i | cfg_resp_v_i;

  // Loopback first and cfg last
  always_comb
  begin
    if (loopback_resp_v_i)
      grant_src = DEST_LOOPBACK;
    else if (dram_resp_v_i)
      grant_src = DEST_DRAM;
    else if (io_resp_v_i)
      grant_src = DEST_IO;
    else
      grant_src = DEST_CFG;
  end

  always_comb
  begin
    case (grant_src)
      DEST_LOOPBACK: resp_sel = loopback_resp_i;
      DEST_DRAM:     resp_sel = dram_resp_i;
      DEST_IO:       resp_sel = io_resp_i;
      default:       resp_sel = cfg_resp_i;
    endcase
  end

  // Same payload on every lane; only the owner sees valid
  for (genvar i = 0; i < NUM_REQ; i++)
  begin : lane
    assign req_resp_o[i]   = resp_sel;
    assign req_resp_v_o[i] = any_v & (resp_sel.src_id == src_id_t'(i));
  end

  assign take = |(req_resp_v_o & req_resp_ready_i);

  assign loopback_resp_yumi_o = take & (grant_src == DEST_LOOPBACK);
  assign dram_resp_yumi_o     = take & (grant_src == DEST_DRAM);
  assign io_resp_yumi_o       = take & (grant_src == DEST_IO);
  assign cfg_resp_yumi_o      = take & (grant_src == DEST_CFG);

endmodule

`default_nettype wire

/* design/cmd_router.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_router
  import ic_pkg::*;
  (  input  mem_msg_t [NUM_REQ-1:0] fifo_data_i
   , input  logic [NUM_REQ-1:0]     fifo_v_i
   , output logic [NUM_REQ-1:0]     fifo_yumi_o

   , output mem_msg_t               cmd_o
   , output logic                   cfg_v_o
   , output logic                   loopback_v_o
   , output logic                   io_v_o
   , output logic                   dram_v_o

   , input  logic                   cfg_ready_i
   , input  logic                   loopback_ready_i
   , input  logic                   io_ready_i
   , input  logic                   dram_ready_i
  );

  logic               all_ready;
  logic [NUM_REQ-1:0] grant;
  logic               dispatch;
  logic               is_local;
  dev_t               dev;
  domain_t            domain;
  dest_e              dest;

  // Any stalled destination holds back every requester
  assign all_ready = cfg_ready_i & loopback_ready_i & io_ready_i & dram_ready_i;

  // Highest index wins so incoming I/O goes first
  always_comb
  begin
    grant = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (fifo_v_i[i])
        grant = NUM_REQ'(1) << i;
    end
  end

  assign fifo_yumi_o = grant & {NUM_REQ{all_ready}};
  assign dispatch    = |fifo_yumi_o;

  always_comb
  begin
    cmd_o = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (grant[i])
        cmd_o = fifo_data_i[i];
    end
  end

  assign is_local = (cmd_o.addr < DRAM_BASE);
  assign dev      = cmd_o.addr[DEV_LSB+:DEV_WIDTH];
  assign domain   = cmd_o.addr[PADDR_WIDTH-1-:DOMAIN_WIDTH];

  always_comb
  begin
    if (is_local)
    begin
      if (dev == DEV_CFG)
        dest = DEST_CFG;
      else if ((dev == DEV_BOOT) || (dev == DEV_HOST))
        dest = DEST_IO;
      else
        dest = DEST_LOOPBACK;
    end
    // Other domains are reached through the I/O port
    else if (domain != '0)
      dest = DEST_IO;
    else
      dest = DEST_DRAM;
  end

  assign cfg_v_o      = dispatch & (dest == DEST_CFG);
  assign loopback_v_o = dispatch & (dest == DEST_LOOPBACK);
  assign io_v_o       = dispatch & (dest == DEST_IO);
  assign dram_v_o     = dispatch & (dest == DEST_DRAM);

endmodule

`default_nettype wire

/* design/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo
  import ic_pkg::*;
  (  input  logic     clk_i
   , input  logic     arst_n_i

   , input  mem_msg_t data_i
   , input  logic     v_i
   , output logic     ready_o

   , output mem_msg_t data_o
   , output logic     v_o
   , input  logic     yumi_i
  );

  mem_msg_t mem_q [2];
  logic     wptr_q;
  logic     rptr_q;
  logic     full_q;
  logic     empty;
  logic     enq;
  logic     deq;

  assign empty   = (wptr_q == rptr_q) & ~full_q;
  assign ready_o = ~full_q;
  assign v_o     = ~empty;
  assign data_o  = mem_q[rptr_q];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_q <= 1'b0;
      rptr_q <= 1'b0;
      full_q <= 1'b0;
    end
    else
    begin
      if (enq)
        wptr_q <= ~wptr_q;
      if (deq)
        rptr_q <= ~rptr_q;
      // Full once a lone enqueue catches up with the read side
      if (enq != deq)
        full_q <= enq & (~wptr_q == rptr_q);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_q[wptr_q] <= data_i;
  end

endmodule

`default_nettype wire

/* design/ic_pkg.sv */
`default_nettype none

package ic_pkg;

  localparam int PADDR_WIDTH  = 40;
  localparam int DATA_WIDTH   = 64;
  localparam int SRC_ID_WIDTH = 2;
  localparam int NUM_REQ      = 3;

  // Local address layout
  localparam int DOMAIN_WIDTH  = 3;
  localparam int DEV_LSB       = 20;
  localparam int DEV_WIDTH     = 4;
  localparam int CFG_IDX_WIDTH = 3;

  typedef logic [PADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [SRC_ID_WIDTH-1:0]  src_id_t;
  typedef logic [DEV_WIDTH-1:0]     dev_t;
  typedef logic [DOMAIN_WIDTH-1:0]  domain_t;
  typedef logic [CFG_IDX_WIDTH-1:0] cfg_idx_t;
  typedef logic                     mem_op_t;

  // Everything below this is local
  localparam addr_t DRAM_BASE = 40'h00_8000_0000;

  localparam dev_t DEV_BOOT = 4'd0;
  localparam dev_t DEV_HOST = 4'd1;
  localparam dev_t DEV_CFG  = 4'd2;

  localparam mem_op_t OP_READ  = 1'b0;
  localparam mem_op_t OP_WRITE = 1'b1;

  // Commands and responses share this layout
  typedef struct packed {
    mem_op_t op;
    addr_t   addr;
    data_t   data;
    src_id_t src_id;
  } mem_msg_t;

  typedef enum logic [1:0] {
    DEST_CFG,
    DEST_LOOPBACK,
    DEST_IO,
    DEST_DRAM
  } dest_e;

endpackage

`default_nettype wire
